// File: hdl/exec_ctrl.sv
`include "rv_cfg.svh"

module exec_ctrl (
    input  logic               clk,
    input  logic               reset,
    input  rv_pkg::decoded_t   dec,
    input  logic [3:0]         irq_request,    // raw interrupt_vector
    input  logic [`XLEN-1:0]   x5_data,
    input  logic [`XLEN-1:0]   bus_read_data,
    output rv_pkg::pc_cmd_e    pc_cmd,
    output rv_pkg::rf_write_t  rf_write,
    output rv_pkg::bus_req_t   bus_req,
    output logic               interrupt_pending,
    output logic               interrupt_ack
);

    localparam logic [4:0] key_reg = 5'd5;  // load target and store source

    rv_pkg::exec_state_e state;
    rv_pkg::exec_state_e state_next;

    logic irq_take;     // interrupt accepted this cycle
    logic issue_read;
    logic issue_write;
    logic do_mret;

    // vector 1 is the only external request and is taken only from st_run
    assign irq_take = (state == rv_pkg::st_run) && (irq_request == 4'd1) &&
                      !interrupt_pending;

    always_comb begin
        state_next  = state;
        pc_cmd      = rv_pkg::pc_step;
        rf_write    = '0;
        issue_read  = 1'b0;
        issue_write = 1'b0;
        do_mret     = 1'b0;
        case (state)
            rv_pkg::st_run: begin
                if (irq_take) begin
                    pc_cmd     = rv_pkg::pc_to_isr;  // word in ir is dropped
                    state_next = rv_pkg::st_bubble;
                end else begin
                    case (dec.op)
                        rv_pkg::op_lui: begin
                            rf_write = '{enable: 1'b1, index: dec.rd, data: dec.imm_u};
                        end
                        rv_pkg::op_load_key: begin
                            pc_cmd     = rv_pkg::pc_hold;
                            issue_read = 1'b1;
                            state_next = rv_pkg::st_load_wait;
                        end
                        rv_pkg::op_store_art: begin
                            pc_cmd      = rv_pkg::pc_hold;
                            issue_write = 1'b1;
                            state_next  = rv_pkg::st_store_done;
                        end
                        rv_pkg::op_mret: begin
                            pc_cmd     = rv_pkg::pc_to_mepc;
                            do_mret    = 1'b1;
                            state_next = rv_pkg::st_bubble;
                        end
                        default: ;  // nop just steps
                    endcase
                end
            end
            rv_pkg::st_load_wait: begin
                pc_cmd     = rv_pkg::pc_hold;  // keep refetching the next word
                rf_write   = '{enable: 1'b1, index: key_reg, data: bus_read_data};
                state_next = rv_pkg::st_bubble;
            end
            rv_pkg::st_store_done: begin
                pc_cmd     = rv_pkg::pc_hold;
                state_next = rv_pkg::st_bubble;
            end
            default: begin
                state_next = rv_pkg::st_run;  // bubble lets pc step on
            end
        endcase
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state             <= rv_pkg::st_bubble;  // reset ir is never executed
            interrupt_pending <= 1'b0;
            interrupt_ack     <= 1'b0;
            bus_req           <= '{address: `KEY_BASE, write_data: '0,
                                   write_enable: 1'b0, read_enable: 1'b0};
        end else begin
            state                <= state_next;
            interrupt_ack        <= irq_take;  // single cycle pulse
            bus_req.read_enable  <= issue_read;
            bus_req.write_enable <= issue_write;
            if (irq_take) begin
                interrupt_pending <= 1'b1;
            end else if (do_mret) begin
                interrupt_pending <= 1'b0;
            end
            if (issue_read) begin
                bus_req.address <= `KEY_BASE;
            end
            if (issue_write) begin
                bus_req.address    <= `ART_BASE;
                bus_req.write_data <= x5_data;  // x5 is the only store source
            end
        end
    end

    a_strobe_excl: assert property (@(posedge clk) disable iff (!reset)
        !(bus_req.read_enable && bus_req.write_enable));

    a_ack_pulse: assert property (@(posedge clk) disable iff (!reset)
        interrupt_ack |=> !interrupt_ack);

    // word fetched on the old path after a redirect sits in the bubble unwritten
    a_no_write_in_bubble: assert property (@(posedge clk) disable iff (!reset)
        (pc_cmd == rv_pkg::pc_to_isr || pc_cmd == rv_pkg::pc_to_mepc) |=>
        (state == rv_pkg::st_bubble) && !rf_write.enable);

endmodule

// File: hdl/instr_decode.sv
`include "rv_cfg.svh"

module instr_decode (
    input  logic [31:0]      ir,
    output rv_pkg::decoded_t dec
);

    // fixed encodings of the custom words
    localparam logic [31:0] mret_word  = 32'h0000_0000;
    localparam logic [31:0] store_word = 32'hffff_ff7f;  // rd field 11110
    localparam logic [31:0] load_word  = 32'hffff_ffff;
    localparam logic [6:0]  lui_opcode = 7'b0110111;

    logic [`XLEN-1:0] imm_u;
    logic [4:0]       rd;

    // upper immediate, low 12 bits zero, sign from bit 31
    assign imm_u = {{(`XLEN-32){ir[31]}}, ir[31:12], 12'h000};
    assign rd    = ir[11:7];

    always_comb begin
        dec.rd    = rd;
        dec.imm_u = imm_u;
        // priority order matters only on paper, encodings are disjoint
        if (ir == mret_word) begin
            dec.op = rv_pkg::op_mret;
        end else if (ir == store_word) begin
            dec.op = rv_pkg::op_store_art;
        end else if (ir == load_word) begin
            dec.op = rv_pkg::op_load_key;
        end else if (ir[6:0] == lui_opcode) begin
            dec.op = rv_pkg::op_lui;
        end else begin
            dec.op = rv_pkg::op_nop;  // everything else falls through
        end
    end

endmodule

// File: hdl/pc_unit.sv
`include "rv_cfg.svh"

module pc_unit (
    input  logic            clk,
    input  logic            reset,
    input  rv_pkg::pc_cmd_e pc_cmd,
    output logic [31:0]     pc,
    output logic [31:0]     ir_pc,   // address of the word now in ir
    output logic [31:0]     mepc     // return address of the service routine
);

    logic [31:0] pc_next;

    always_comb begin
        case (pc_cmd)
            rv_pkg::pc_hold:    pc_next = pc;
            rv_pkg::pc_to_isr:  pc_next = `ISR_ADDR;
            rv_pkg::pc_to_mepc: pc_next = mepc;
            default:            pc_next = pc + 32'd4;  // pc_step
        endcase
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pc <= `RESET_PC;
        end else begin
            pc <= pc_next;
        end
    end

    // ir_pc trails pc by one cycle, same as ir trails instruction
    always_ff @(posedge clk) begin
        ir_pc <= pc;
        if (pc_cmd == rv_pkg::pc_to_isr) begin
            mepc <= ir_pc;  // the dropped word gets re-executed after mret
        end
    end

    a_pc_aligned: assert property (@(posedge clk) disable iff (!reset)
        pc[1:0] == 2'b00);

endmodule

// File: hdl/reg_file.sv
`include "rv_cfg.svh"

module reg_file (
    input  logic              clk,
    input  rv_pkg::rf_write_t rf_write,
    output logic [`XLEN-1:0]  x5_data
);

    localparam logic [4:0] x5_index = 5'd5;

    // x1..x31 only, x0 has no storage and reads as zero
    logic [`XLEN-1:0] regs [1:31];

    always_ff @(posedge clk) begin
        if (rf_write.enable && (rf_write.index != 5'd0)) begin
            regs[rf_write.index] <= rf_write.data;  // writes to x0 dropped
        end
    end

    // store source, no read latency
    assign x5_data = regs[x5_index];

endmodule

// File: hdl/rv_cfg.svh
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// integer register and bus data width
`define XLEN 64

// first fetch address out of reset
`define RESET_PC 32'h0000_0000

// fixed entry point of the interrupt service routine
`define ISR_ADDR 32'h0000_0100

// memory mapped devices on the data bus
`define KEY_BASE 64'h0000_0000_1000_0000  // keyboard, read by the key load
`define ART_BASE 64'h0000_0000_8000_0000  // display, written by the art store

`endif

// File: hdl/rv_core.sv
`include "rv_cfg.svh"

module rv_core (
    input  logic               clk,
    input  logic               reset,
    input  logic [31:0]        instruction,
    output logic [31:0]        pc,
    output logic               heartbeat,
    input  logic [3:0]         interrupt_vector,
    output logic               interrupt_pending,
    output logic               interrupt_ack,
    output logic [`XLEN-1:0]   bus_address,
    output logic [`XLEN-1:0]   bus_write_data,
    output logic               bus_write_enable,
    output logic               bus_read_enable,
    input  logic [`XLEN-1:0]   bus_read_data
);

    logic [31:0]        ir;        // fetch stage, one word deep
    rv_pkg::decoded_t   dec;
    rv_pkg::pc_cmd_e    pc_cmd;
    rv_pkg::rf_write_t  rf_write;
    rv_pkg::bus_req_t   bus_req;
    logic [`XLEN-1:0]   x5_data;

    // ir loads every edge, the execute FSM decides what to drop
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            ir        <= 32'h0000_0013;  // plain nop
            heartbeat <= 1'b0;
        end else begin
            ir        <= instruction;
            heartbeat <= ~heartbeat;      // alive indicator
        end
    end

    instr_decode u_decode (
        .ir  (ir),
        .dec (dec)
    );

    exec_ctrl u_exec (
        .clk               (clk),
        .reset             (reset),
        .dec               (dec),
        .irq_request       (interrupt_vector),
        .x5_data           (x5_data),
        .bus_read_data     (bus_read_data),
        .pc_cmd            (pc_cmd),
        .rf_write          (rf_write),
        .bus_req           (bus_req),
        .interrupt_pending (interrupt_pending),
        .interrupt_ack     (interrupt_ack)
    );

    // ir_pc and mepc only feed the pc mux inside pc_unit
    pc_unit u_pc (
        .clk    (clk),
        .reset  (reset),
        .pc_cmd (pc_cmd),
        .pc     (pc),
        .ir_pc  (),
        .mepc   ()
    );

    reg_file u_regs (
        .clk      (clk),
        .rf_write (rf_write),
        .x5_data  (x5_data)
    );

    // bus request straight from the exec registers
    assign bus_address      = bus_req.address;
    assign bus_write_data   = bus_req.write_data;
    assign bus_write_enable = bus_req.write_enable;
    assign bus_read_enable  = bus_req.read_enable;

endmodule

// File: hdl/rv_pkg.sv
`include "rv_cfg.svh"

package rv_pkg;

    // decoded operation, one of the five the core knows
    typedef enum logic [2:0] {
        op_nop,
        op_lui,
        op_load_key,   // all ones word
        op_store_art,  // all ones, rd = 11110
        op_mret        // all zero word
    } op_kind_e;

    // execute stage states
    typedef enum logic [1:0] {
        st_run,
        st_bubble,      // ir holds a stale word, drop it
        st_load_wait,   // read data comes back here
        st_store_done
    } exec_state_e;

    // what the pc does at the next edge
    typedef enum logic [1:0] {
        pc_step,     // +4
        pc_hold,
        pc_to_isr,   // jump to service routine, save return address
        pc_to_mepc   // return from service routine
    } pc_cmd_e;

    typedef struct packed {
        op_kind_e              op;
        logic [4:0]            rd;
        logic [`XLEN-1:0]      imm_u;  // already sign extended
    } decoded_t;

    typedef struct packed {
        logic [`XLEN-1:0]      address;
        logic [`XLEN-1:0]      write_data;
        logic                  write_enable;
        logic                  read_enable;
    } bus_req_t;

    typedef struct packed {
        logic                  enable;
        logic [4:0]            index;
        logic [`XLEN-1:0]      data;
    } rf_write_t;

endpackage

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the rv_core testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_rv_core -f tb.f -o sim_tb_rv_core
./obj_dir/sim_tb_rv_core

// File: tb.f
+incdir+hdl
hdl/rv_pkg.sv
hdl/instr_decode.sv
hdl/exec_ctrl.sv
hdl/pc_unit.sv
hdl/reg_file.sv
hdl/rv_core.sv
tb/tb_rv_core.sv

// File: tb/rv_core_vectors.txt
// one 32-bit hex word per line, @ gives the word index
// 00-5f program and service routine, 70 write count, 71 ack count, 78.. irq cycles ending in 0
@00
123452b7  // lui x5, 0x12345
ffffff7f  // art store of x5
abcde037  // lui x0, write dropped
ffffff7f  // same data again
876542b7  // lui x5, negative immediate
ffffff7f
ffffffff  // key load into x5
ffffff7f  // store the key value
00000013
00000013
00000013
00000013
0beef2b7  // lui x5, 0x0beef
ffffff7f  // dropped by the interrupt, rerun after mret
@40
00000013  // service routine at 0x100
00000013
00000013
00000000  // mret
@70
00000005
00000001
@78
00000018  // taken while ir holds the store
0000001a  // arrives during service, no ack
00000000

// File: tb/tb_rv_core.sv
`include "rv_cfg.svh"

module tb_rv_core;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int m_run        = 0;  // model states
    localparam int m_bubble     = 1;
    localparam int m_load_wait  = 2;
    localparam int m_store_done = 3;
    localparam int prog_words   = 96;  // fetch above the image area returns fill
    localparam int max_cycles   = 200;
    localparam logic [31:0] store_word = 32'hffff_ff7f;
    localparam logic [31:0] load_word  = 32'hffff_ffff;

    logic        clk;
    logic        reset;
    logic [31:0] instruction;
    logic [31:0] pc;
    logic        heartbeat;
    logic [3:0]  interrupt_vector;
    logic        interrupt_pending;
    logic        interrupt_ack;
    logic [63:0] bus_address;
    logic [63:0] bus_write_data;
    logic        bus_write_enable;
    logic        bus_read_enable;
    logic [63:0] bus_read_data;

    logic [31:0] mem [0:127];  // program with counts at 0x70 and irq cycles from 0x78
    int          irq_cycles [0:7];
    int          n_irq;
    int          expected_writes;
    int          expected_acks;
    int          cycle;
    int          writes_seen;
    int          acks_seen;
    logic        seen_isr;
    logic        seen_ignored;  // request while already in service

    // reference model of the core
    int          m_state;
    logic [31:0] m_pc;
    logic [31:0] m_ir;
    logic [31:0] m_ir_pc;
    logic [31:0] m_mepc;
    logic        m_pending;
    logic        m_ack;
    logic        m_rd;
    logic        m_wr;
    logic        m_hb;
    logic [63:0] m_x5;
    logic [63:0] m_wdata;

    rv_core UUT (
        .clk               (clk),
        .reset             (reset),
        .instruction       (instruction),
        .pc                (pc),
        .heartbeat         (heartbeat),
        .interrupt_vector  (interrupt_vector),
        .interrupt_pending (interrupt_pending),
        .interrupt_ack     (interrupt_ack),
        .bus_address       (bus_address),
        .bus_write_data    (bus_write_data),
        .bus_write_enable  (bus_write_enable),
        .bus_read_enable   (bus_read_enable),
        .bus_read_data     (bus_read_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // 4 ns period
    end

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            fail_run($sformatf("ERR %s expected %h actual %h", name, expected, actual));
        end
    endtask

    // op-imm nop whose fields carry the folded word index
    function automatic logic [31:0] fill_word(input logic [31:0] idx);
        return {idx[24:0] ^ {20'd0, idx[29:25]}, 7'b0010011};
    endfunction

    function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        logic [31:0] idx;
        idx = addr >> 2;
        if (idx < prog_words) begin
            return mem[idx[6:0]];
        end else begin
            return fill_word(idx);
        end
    endfunction

    function automatic logic is_irq_cycle(input int c);
        logic hit;
        hit = 1'b0;
        for (int i = 0; i < n_irq; i++) begin
            if (irq_cycles[3'(i)] == c) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    task automatic load_image();
        for (int i = 0; i < 128; i++) begin
            mem[7'(i)] = fill_word(32'(i));
        end
        $readmemh("tb/rv_core_vectors.txt", mem);  // overwrites listed words only
        expected_writes = int'(mem[7'h70]);
        expected_acks   = int'(mem[7'h71]);
        n_irq = 0;
        while ((n_irq < 8) && (mem[7'(n_irq + 120)] != 32'd0)) begin  // zero ends list
            irq_cycles[3'(n_irq)] = int'(mem[7'(n_irq + 120)]);
            n_irq++;
        end
    endtask

    // one clock edge of the model on the inputs held before the edge
    task automatic model_step();
        logic        take;
        logic [31:0] nxt_pc;
        int          nxt_state;
        take      = (m_state == m_run) && (interrupt_vector == 4'd1) && !m_pending;
        nxt_pc    = m_pc + 32'd4;
        nxt_state = m_run;
        m_ack     = take;
        m_rd      = 1'b0;
        m_wr      = 1'b0;
        if ((m_state == m_run) && (interrupt_vector == 4'd1) && m_pending) begin
            seen_ignored = 1'b1;
        end
        if (m_state == m_run) begin
            if (take) begin
                m_mepc    = m_ir_pc;  // dropped word is rerun after mret
                m_pending = 1'b1;
                nxt_pc    = `ISR_ADDR;
                nxt_state = m_bubble;
            end else if (m_ir == 32'd0) begin  // mret
                nxt_pc    = m_mepc;
                m_pending = 1'b0;
                nxt_state = m_bubble;
            end else if (m_ir == store_word) begin
                nxt_pc    = m_pc;
                m_wr      = 1'b1;
                m_wdata   = m_x5;
                nxt_state = m_store_done;
            end else if (m_ir == load_word) begin
                nxt_pc    = m_pc;
                m_rd      = 1'b1;
                nxt_state = m_load_wait;
            end else if ((m_ir[6:0] == 7'b0110111) && (m_ir[11:7] == 5'd5)) begin
                m_x5 = 64'($signed({m_ir[31:12], 12'h000}));  // lui x5 only
            end
        end else if (m_state == m_load_wait) begin
            m_x5      = bus_read_data;  // key value returned for the strobe
            nxt_pc    = m_pc;
            nxt_state = m_bubble;
        end else if (m_state == m_store_done) begin
            nxt_pc    = m_pc;
            nxt_state = m_bubble;
        end
        m_ir    = instruction;
        m_ir_pc = m_pc;
        m_pc    = nxt_pc;
        m_state = nxt_state;
        m_hb    = ~m_hb;
    endtask

    task automatic compare_outputs();
        check_value("pc", 64'(m_pc), 64'(pc));
        check_value("heartbeat", 64'(m_hb), 64'(heartbeat));
        check_value("interrupt_ack", 64'(m_ack), 64'(interrupt_ack));
        check_value("interrupt_pending", 64'(m_pending), 64'(interrupt_pending));
        check_value("bus_write_enable", 64'(m_wr), 64'(bus_write_enable));
        check_value("bus_read_enable", 64'(m_rd), 64'(bus_read_enable));
        if (m_wr) begin
            check_value("art_address", `ART_BASE, bus_address);
            check_value("art_data", m_wdata, bus_write_data);
        end
        if (m_rd) begin
            check_value("key_address", `KEY_BASE, bus_address);
        end
    endtask

    task automatic drive_inputs();
        instruction      = fetch_word(pc);
        interrupt_vector = is_irq_cycle(cycle) ? 4'd1 : 4'd0;
        if (bus_read_enable) begin
            bus_read_data = {$urandom, $urandom};  // fresh key per load
        end
    endtask

    initial begin
        void'($urandom(32'hd42d3987));
        reset            = 1'b0;
        instruction      = 32'h0000_0013;
        interrupt_vector = 4'd0;
        bus_read_data    = 64'd0;
        cycle            = 0;
        writes_seen      = 0;
        acks_seen        = 0;
        seen_isr         = 1'b0;
        seen_ignored     = 1'b0;
        load_image();

        repeat (8) begin
            @(posedge clk);
            #1;
            drive_inputs();
        end
        // core still held in reset
        check_value("reset_pc", 64'(`RESET_PC), 64'(pc));
        check_value("reset_write_enable", 64'd0, 64'(bus_write_enable));
        check_value("reset_read_enable", 64'd0, 64'(bus_read_enable));
        check_value("reset_ack", 64'd0, 64'(interrupt_ack));
        check_value("reset_pending", 64'd0, 64'(interrupt_pending));
        check_value("reset_heartbeat", 64'd0, 64'(heartbeat));
        check_value("reset_bus_address", `KEY_BASE, bus_address);

        m_state   = m_bubble;  // reset ir is never executed
        m_pc      = `RESET_PC;
        m_ir      = 32'h0000_0013;
        m_ir_pc   = `RESET_PC;
        m_mepc    = `RESET_PC;
        m_pending = 1'b0;
        m_hb      = 1'b0;
        m_x5      = 64'd0;
        m_wdata   = 64'd0;
        reset     = 1'b1;

        while (writes_seen < expected_writes) begin
            if (cycle >= max_cycles) begin
                fail_run("timeout waiting for the expected display writes");
            end
            @(posedge clk);
            model_step();
            cycle++;
            #1;
            compare_outputs();
            if (bus_write_enable) begin
                writes_seen++;
            end
            if (interrupt_ack) begin
                acks_seen++;
            end
            if (pc == `ISR_ADDR) begin
                seen_isr = 1'b1;
            end
            drive_inputs();
        end

        check_value("ack_count", 64'(expected_acks), 64'(acks_seen));
        check_value("isr_reached", 64'd1, 64'(seen_isr));
        check_value("request_in_service", 64'd1, 64'(seen_ignored));
        $display("Simulation completed successfully");
        $finish;
    end

endmodule
